/* verilog/soc_l2_pkg.sv */
package soc_l2_pkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;

    // Masters: 0 is fc data, 1 is fc instr
    localparam int NR_MASTERS = 2;
    localparam int MST_IDX_W  = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;
    typedef logic [MST_IDX_W-1:0] mst_idx_t;

    // Contiguous banks that follow the interleaved ones in target numbering
    localparam int NR_PRIV_BANKS = 2;

    // Word index inside one bank, sized for the largest legal bank
    localparam int MAX_BANK_WORDS_W = 10;
    typedef logic [MAX_BANK_WORDS_W-1:0] word_idx_t;

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////

    localparam addr_t PRIV0_START    = 32'h1C00_0000;
    localparam addr_t PRIV1_START    = 32'h1C00_8000;
    localparam addr_t L2_INTLV_START = 32'h1C01_0000;

    // Legacy prefix alias of the fc data port
    localparam logic [11:0] ALIAS_FROM = 12'h000;
    localparam logic [11:0] ALIAS_TO   = 12'h1C0;

    // Interleaved banks first, then private 0 and 1, all ones for a miss
    typedef logic [2:0] target_t;
    localparam target_t TGT_NONE = 3'b111;

    //////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////

    // TCDM request, wen high is a read
    typedef struct packed {
        logic  req;
        logic  wen;
        addr_t add;
        data_t wdata;
        be_t   be;
    } tcdm_req_t;

    // TCDM response, r_opc high flags an error
    typedef struct packed {
        logic  r_valid;
        logic  r_opc;
        data_t r_rdata;
    } tcdm_rsp_t;

    // Access as seen by a bank after decoding
    typedef struct packed {
        logic      wen;
        word_idx_t word_idx;
        data_t     wdata;
        be_t       be;
    } l2_acc_t;

    // Where a request goes
    typedef struct packed {
        logic    valid;
        target_t target;
    } l2_route_t;

endpackage

/* verilog/l2_addr_decoder.sv */
`timescale 1ns/10ps

module l2_addr_decoder
    import soc_l2_pkg::*;
#(
    parameter int NR_L2_PORTS = 4,
    parameter int BANK_WORDS  = 256,
    parameter bit REMAP_ALIAS = 1'b0
) (
    input  tcdm_req_t req_i,
    output l2_route_t route_o,
    output l2_acc_t   acc_o
);

    // Region sizes in bytes
    localparam addr_t BANK_BYTES  = addr_t'(BANK_WORDS * 4);
    localparam addr_t INTLV_BYTES = addr_t'(NR_L2_PORTS * BANK_WORDS * 4);

    addr_t       add_remap;
    addr_t       off_priv0;
    addr_t       off_priv1;
    addr_t       off_intlv;
    logic [29:0] intlv_word;

    //////////////////////////////////////////////////
    // Alias remap
    //////////////////////////////////////////////////

    always_comb begin
        add_remap = req_i.add;
        // Only the data port folds 0x000xxxxx onto 0x1C0xxxxx
        if (REMAP_ALIAS && (req_i.add[31:20] == ALIAS_FROM)) begin
            add_remap[31:20] = ALIAS_TO;
        end
    end

    // Offsets wrap to huge values below a region start, so one compare per region
    assign off_priv0  = add_remap - PRIV0_START;
    assign off_priv1  = add_remap - PRIV1_START;
    assign off_intlv  = add_remap - L2_INTLV_START;
    assign intlv_word = off_intlv[31:2];

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////

    always_comb begin
        route_o.valid  = req_i.req;
        route_o.target = TGT_NONE;
        // Payload passes unchanged
        acc_o.wen      = req_i.wen;
        acc_o.wdata    = req_i.wdata;
        acc_o.be       = req_i.be;
        acc_o.word_idx = '0;
        if (off_intlv < INTLV_BYTES) begin
            // Low word bits pick the bank, the rest index into it
            route_o.target = target_t'(intlv_word % NR_L2_PORTS);
            acc_o.word_idx = word_idx_t'(intlv_word / NR_L2_PORTS);
        end else if (off_priv0 < BANK_BYTES) begin
            route_o.target = target_t'(NR_L2_PORTS);
            acc_o.word_idx = word_idx_t'(off_priv0[31:2]);
        end else if (off_priv1 < BANK_BYTES) begin
            route_o.target = target_t'(NR_L2_PORTS + 1);
            acc_o.word_idx = word_idx_t'(off_priv1[31:2]);
        end
    end

endmodule

/* verilog/l2_arbiter.sv */
`timescale 1ns/10ps

module l2_arbiter
    import soc_l2_pkg::*;
#(
    parameter int NR_L2_PORTS = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  l2_route_t             route_i [NR_MASTERS],
    output logic [NR_MASTERS-1:0] gnt_o,
    output logic [NR_L2_PORTS+NR_PRIV_BANKS-1:0] bank_en_o,
    output mst_idx_t              bank_sel_o [NR_L2_PORTS+NR_PRIV_BANKS],
    output logic [NR_MASTERS-1:0] granted_o,
    output target_t               granted_tgt_o [NR_MASTERS]
);

    localparam int NR_TGT = NR_L2_PORTS + NR_PRIV_BANKS;

    // Requesters per target
    logic [NR_MASTERS-1:0] tgt_req [NR_TGT];

    // Round-robin pointer per target, points at the favoured master
    mst_idx_t rr_q [NR_TGT];
    mst_idx_t rr_d [NR_TGT];

    always_comb begin
        for (int b = 0; b < NR_TGT; b++) begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                tgt_req[b][m] = route_i[m].valid && (route_i[m].target == target_t'(b));
            end
        end
    end

    //////////////////////////////////////////////////
    // Grant decision
    //////////////////////////////////////////////////

    always_comb begin : arbitrate
        int cand;

        cand      = 0;
        gnt_o     = '0;
        bank_en_o = '0;

        // Misses go straight through to the error response
        for (int m = 0; m < NR_MASTERS; m++) begin
            if (route_i[m].valid && (route_i[m].target == TGT_NONE)) begin
                gnt_o[m] = 1'b1;
            end
        end

        for (int b = 0; b < NR_TGT; b++) begin
            bank_sel_o[b] = '0;
            rr_d[b]       = rr_q[b];
            // Scan masters starting at the pointer, first hit wins
            for (int k = 0; k < NR_MASTERS; k++) begin
                cand = (int'(rr_q[b]) + k) % NR_MASTERS;
                if (!bank_en_o[b] && tgt_req[b][cand]) begin
                    bank_en_o[b]  = 1'b1;
                    bank_sel_o[b] = mst_idx_t'(cand);
                    gnt_o[cand]   = 1'b1;
                    // Pointer only moves when someone else was waiting
                    if ($countones(tgt_req[b]) > 1) begin
                        rr_d[b] = mst_idx_t'((cand + 1) % NR_MASTERS);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Pointer state
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < NR_TGT; b++) begin
            if (!rst_n_i) begin
                // Master 0 first after reset
                rr_q[b] <= '0;
            end else begin
                rr_q[b] <= rr_d[b];
            end
        end
    end

    // Grant report for the response stage
    assign granted_o = gnt_o;

    always_comb begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            granted_tgt_o[m] = route_i[m].target;
        end
    end

endmodule

/* verilog/l2_bank.sv */
`timescale 1ns/10ps

module l2_bank
    import soc_l2_pkg::*;
#(
    parameter int BANK_WORDS = 256
) (
    input  logic     clk_i,
    input  l2_acc_t  acc_i [NR_MASTERS],
    input  logic     en_i,
    input  mst_idx_t sel_i,
    output data_t    rdata_o
);

    localparam int IDX_W = $clog2(BANK_WORDS);

    data_t             mem_q [BANK_WORDS];
    l2_acc_t           acc;
    logic [IDX_W-1:0]  addr;

    // Access of the master that won this bank
    assign acc  = acc_i[sel_i];
    assign addr = acc.word_idx[IDX_W-1:0];

    //////////////////////////////////////////////////
    // Single port array
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (acc.wen) begin
                // Read word shows up one cycle after grant
                rdata_o <= mem_q[addr];
            end else begin
                // Byte lanes written only where enabled
                for (int i = 0; i < 4; i++) begin
                    if (acc.be[i]) begin
                        mem_q[addr][8*i +: 8] <= acc.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

/* verilog/l2_resp_mux.sv */
`timescale 1ns/10ps

module l2_resp_mux
    import soc_l2_pkg::*;
#(
    parameter int NR_L2_PORTS = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [NR_MASTERS-1:0] granted_i,
    input  target_t               granted_tgt_i [NR_MASTERS],
    input  data_t                 bank_rdata_i [NR_L2_PORTS+NR_PRIV_BANKS],
    output tcdm_rsp_t             rsp_o [NR_MASTERS]
);

    localparam int NR_TGT = NR_L2_PORTS + NR_PRIV_BANKS;

    // One outstanding access per master
    logic [NR_MASTERS-1:0] vld_q;
    target_t               tgt_q [NR_MASTERS];

    //////////////////////////////////////////////////
    // Grant capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= granted_i;
        end
    end

    // Target only matters while vld_q is set
    always_ff @(posedge clk_i) begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            if (granted_i[m]) begin
                tgt_q[m] <= granted_tgt_i[m];
            end
        end
    end

    //////////////////////////////////////////////////
    // Response build
    //////////////////////////////////////////////////

    always_comb begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            rsp_o[m].r_valid = vld_q[m];
            // Miss answers with error and zero data
            rsp_o[m].r_opc   = vld_q[m] && (tgt_q[m] == TGT_NONE);
            rsp_o[m].r_rdata = '0;
            if (tgt_q[m] < NR_TGT) begin
                rsp_o[m].r_rdata = bank_rdata_i[tgt_q[m]];
            end
        end
    end

endmodule

/* verilog/soc_l2_top.sv */
`timescale 1ns/10ps

module soc_l2_top
    import soc_l2_pkg::*;
#(
    parameter int NR_L2_PORTS = 4,
    parameter int BANK_WORDS  = 256
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // fc data port
    input  tcdm_req_t fc_data_req_i,
    output logic      fc_data_gnt_o,
    output tcdm_rsp_t fc_data_rsp_o,
    // fc instruction port
    input  tcdm_req_t fc_instr_req_i,
    output logic      fc_instr_gnt_o,
    output tcdm_rsp_t fc_instr_rsp_o
);

    localparam int NR_TGT = NR_L2_PORTS + NR_PRIV_BANKS;

    l2_route_t             route [NR_MASTERS];
    l2_acc_t               acc [NR_MASTERS];
    logic [NR_MASTERS-1:0] gnt;
    logic [NR_TGT-1:0]     bank_en;
    mst_idx_t              bank_sel [NR_TGT];
    logic [NR_MASTERS-1:0] granted;
    target_t               granted_tgt [NR_MASTERS];
    data_t                 bank_rdata [NR_TGT];
    tcdm_rsp_t             rsp [NR_MASTERS];

    //////////////////////////////////////////////////
    // Address decode per master
    //////////////////////////////////////////////////

    // Data port keeps the legacy 0x000 alias
    l2_addr_decoder #(
        .NR_L2_PORTS(NR_L2_PORTS),
        .BANK_WORDS (BANK_WORDS),
        .REMAP_ALIAS(1'b1)
    ) u_dec_data (
        .req_i  (fc_data_req_i),
        .route_o(route[0]),
        .acc_o  (acc[0])
    );

    l2_addr_decoder #(
        .NR_L2_PORTS(NR_L2_PORTS),
        .BANK_WORDS (BANK_WORDS),
        .REMAP_ALIAS(1'b0)
    ) u_dec_instr (
        .req_i  (fc_instr_req_i),
        .route_o(route[1]),
        .acc_o  (acc[1])
    );

    // Per target round-robin
    l2_arbiter #(
        .NR_L2_PORTS(NR_L2_PORTS)
    ) u_arb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .route_i      (route),
        .gnt_o        (gnt),
        .bank_en_o    (bank_en),
        .bank_sel_o   (bank_sel),
        .granted_o    (granted),
        .granted_tgt_o(granted_tgt)
    );

    //////////////////////////////////////////////////
    // Memory banks
    //////////////////////////////////////////////////

    // Word interleaved region
    for (genvar b = 0; b < NR_L2_PORTS; b++) begin : g_intlv
        l2_bank #(
            .BANK_WORDS(BANK_WORDS)
        ) u_bank (
            .clk_i  (clk_i),
            .acc_i  (acc),
            .en_i   (bank_en[b]),
            .sel_i  (bank_sel[b]),
            .rdata_o(bank_rdata[b])
        );
    end

    // Contiguous private banks sit right after the interleaved targets
    l2_bank #(
        .BANK_WORDS(BANK_WORDS)
    ) u_priv0 (
        .clk_i  (clk_i),
        .acc_i  (acc),
        .en_i   (bank_en[NR_L2_PORTS]),
        .sel_i  (bank_sel[NR_L2_PORTS]),
        .rdata_o(bank_rdata[NR_L2_PORTS])
    );

    l2_bank #(
        .BANK_WORDS(BANK_WORDS)
    ) u_priv1 (
        .clk_i  (clk_i),
        .acc_i  (acc),
        .en_i   (bank_en[NR_L2_PORTS+1]),
        .sel_i  (bank_sel[NR_L2_PORTS+1]),
        .rdata_o(bank_rdata[NR_L2_PORTS+1])
    );

    // Response one cycle after grant
    l2_resp_mux #(
        .NR_L2_PORTS(NR_L2_PORTS)
    ) u_resp (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .granted_i    (granted),
        .granted_tgt_i(granted_tgt),
        .bank_rdata_i (bank_rdata),
        .rsp_o        (rsp)
    );

    // Master ports
    assign fc_data_gnt_o  = gnt[0];
    assign fc_instr_gnt_o = gnt[1];
    assign fc_data_rsp_o  = rsp[0];
    assign fc_instr_rsp_o = rsp[1];

endmodule

/* bench/soc_l2_checker.sv */
`timescale 1ns/10ps

module soc_l2_checker
    import soc_l2_pkg::*;
#(
    parameter int NR_L2_PORTS = 4,
    parameter int BANK_WORDS  = 256
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  tcdm_req_t data_req_i,
    input  tcdm_req_t instr_req_i,
    input  logic      data_gnt_i,
    input  logic      instr_gnt_i,
    input  tcdm_rsp_t data_rsp_i,
    input  tcdm_rsp_t instr_rsp_i,
    input  int        test_id_i,
    output int        data_err_o,
    output int        proto_err_o,
    output int        pending_o
);

    // Expected response, mask picks the bytes that must match
    typedef struct packed {
        logic  err;
        data_t data;
        data_t mask;
    } exp_t;

    exp_t  exp_q [NR_MASTERS][$];
    data_t mem_data [int unsigned];
    data_t mem_mask [int unsigned];
    int    winner [NR_L2_PORTS+2];

    initial begin
        data_err_o  = 0;
        proto_err_o = 0;
        pending_o   = 0;
        foreach (winner[t]) winner[t] = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "private";
            2: return "alias";
            3: return "interleave";
            4: return "conflict";
            5: return "parallel";
            default: return "idle";
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic addr_t remap(input int m, input addr_t a);
        if (m == 0 && a[31:20] == 12'h000) a[31:20] = 12'h1C0;
        return a;
    endfunction

    // Target of an address, -1 for a miss
    function automatic int target_of(input int m, input addr_t a);
        addr_t r;
        r = remap(m, a);
        if (r >= 32'h1C01_0000 && r < 32'h1C01_0000 + NR_L2_PORTS * BANK_WORDS * 4)
            return ((r - 32'h1C01_0000) >> 2) % NR_L2_PORTS;
        if (r >= 32'h1C00_0000 && r < 32'h1C00_0000 + BANK_WORDS * 4) return NR_L2_PORTS;
        if (r >= 32'h1C00_8000 && r < 32'h1C00_8000 + BANK_WORDS * 4) return NR_L2_PORTS + 1;
        return -1;
    endfunction

    function automatic exp_t expect_rsp(input int m, input tcdm_req_t r);
        exp_t        e;
        int unsigned w;
        w = remap(m, r.add) >> 2;
        e = '0;
        if (target_of(m, r.add) < 0) begin
            // Miss must answer with zero data
            e.err  = 1'b1;
            e.mask = '1;
        end else if (r.wen && mem_data.exists(w)) begin
            e.data = mem_data[w];
            e.mask = mem_mask[w];
        end
        return e;
    endfunction

    task automatic update_model(input int m, input tcdm_req_t r);
        int unsigned w;
        w = remap(m, r.add) >> 2;
        if (target_of(m, r.add) >= 0 && !r.wen) begin
            if (!mem_data.exists(w)) begin
                mem_data[w] = '0;
                mem_mask[w] = '0;
            end
            for (int i = 0; i < 4; i++) begin
                if (r.be[i]) begin
                    mem_data[w][8*i +: 8] = r.wdata[8*i +: 8];
                    mem_mask[w][8*i +: 8] = 8'hFF;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Comparison
    //////////////////////////////////////////////////

    always @(posedge clk_i) begin : compare
        tcdm_req_t             req [NR_MASTERS];
        tcdm_rsp_t             rsp [NR_MASTERS];
        logic [NR_MASTERS-1:0] gnt;
        logic [NR_MASTERS-1:0] exp_gnt;
        int                    tgt [NR_MASTERS];
        logic                  clash;
        exp_t                  e;

        req[0] = data_req_i;
        req[1] = instr_req_i;
        rsp[0] = data_rsp_i;
        rsp[1] = instr_rsp_i;
        gnt    = {instr_gnt_i, data_gnt_i};
        if (rst_n_i) begin
            // Responses to last cycle's grants
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (rsp[m].r_valid) begin
                    if (exp_q[m].size() == 0) begin
                        $display("Master %0d got a response with no access pending", m);
                        proto_err_o++;
                    end else begin
                        e = exp_q[m].pop_front();
                        if (rsp[m].r_opc !== e.err) begin
                            $display("ERR %s m%0d r_opc exp %b got %b", test_name(test_id_i),
                                     m, e.err, rsp[m].r_opc);
                            data_err_o++;
                        end else if (((rsp[m].r_rdata ^ e.data) & e.mask) !== '0) begin
                            $display("ERR %s m%0d rdata exp %h got %h", test_name(test_id_i),
                                     m, e.data & e.mask, rsp[m].r_rdata & e.mask);
                            data_err_o++;
                        end
                    end
                end
            end
            // Grants follow per target round-robin
            for (int m = 0; m < NR_MASTERS; m++) begin
                tgt[m] = req[m].req ? target_of(m, req[m].add) : -1;
            end
            clash = req[0].req && req[1].req && tgt[0] >= 0 && tgt[0] == tgt[1];
            for (int m = 0; m < NR_MASTERS; m++) begin
                exp_gnt[m] = req[m].req && (!clash || winner[tgt[0]] == m);
            end
            if (gnt !== exp_gnt) begin
                $display("ERR %s gnt exp %b got %b", test_name(test_id_i), exp_gnt, gnt);
                data_err_o++;
            end
            if (clash) winner[tgt[0]] = 1 - winner[tgt[0]];
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (req[m].req && gnt[m]) begin
                    exp_q[m].push_back(expect_rsp(m, req[m]));
                    update_model(m, req[m]);
                end
            end
        end
        pending_o = exp_q[0].size() + exp_q[1].size();
    end

endmodule

/* bench/soc_l2_sva.sv */
`timescale 1ns/10ps

module soc_l2_sva
    import soc_l2_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input tcdm_req_t fc_data_req_i,
    input logic      fc_data_gnt_o,
    input tcdm_rsp_t fc_data_rsp_o,
    input tcdm_req_t fc_instr_req_i,
    input logic      fc_instr_gnt_o,
    input tcdm_rsp_t fc_instr_rsp_o
);

    logic [1:0] req;
    logic [1:0] gnt;
    logic [1:0] vld;
    logic [1:0] opc_bad;
    // Failed assertions so far
    int         fail_cnt = 0;

    assign req     = {fc_instr_req_i.req, fc_data_req_i.req};
    assign gnt     = {fc_instr_gnt_o, fc_data_gnt_o};
    assign vld     = {fc_instr_rsp_o.r_valid, fc_data_rsp_o.r_valid};
    // Error response carrying data
    assign opc_bad = {fc_instr_rsp_o.r_opc && (fc_instr_rsp_o.r_rdata != '0),
                      fc_data_rsp_o.r_opc && (fc_data_rsp_o.r_rdata != '0)};

    a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (gnt & ~req) == 2'b00)
        else begin
            $error("gnt without req");
            fail_cnt++;
        end

    a_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ##1 vld == $past(req & gnt))
        else begin
            $error("r_valid not one cycle after grant");
            fail_cnt++;
        end

    a_err_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        opc_bad == 2'b00)
        else begin
            $error("r_opc with nonzero r_rdata");
            fail_cnt++;
        end

endmodule

/* bench/soc_l2_tb.sv */
`timescale 1ns/10ps

module soc_l2_tb
    import soc_l2_pkg::*;
;

    localparam int NP = 4;
    localparam int BW = 256;
    // Iterations per test
    localparam int N1 = 40;
    localparam int N2 = 16;
    localparam int N3 = 64;
    localparam int N4 = 32;
    localparam int N5 = 16;
    localparam int NR_TXN = 4 * N1 + 3 * N2 + 4 * N3 + 2 * N4 + 6 * N5;
    localparam int CYCLE_LIMIT = 4 * NR_TXN + 200;

    logic                  clk_i;
    logic                  rst_n_i;
    tcdm_req_t             req [NR_MASTERS];
    logic [NR_MASTERS-1:0] gnt;
    tcdm_rsp_t             rsp [NR_MASTERS];
    int                    test_id;
    int                    cycles;
    int                    seed;
    int                    data_err;
    int                    proto_err;
    int                    sva_err;
    int                    pending;
    addr_t                 a0 [N1];
    addr_t                 a1 [N1];

    soc_l2_top #(.NR_L2_PORTS(NP), .BANK_WORDS(BW)) u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fc_data_req_i (req[0]),
        .fc_data_gnt_o (gnt[0]),
        .fc_data_rsp_o (rsp[0]),
        .fc_instr_req_i(req[1]),
        .fc_instr_gnt_o(gnt[1]),
        .fc_instr_rsp_o(rsp[1])
    );

    soc_l2_checker #(.NR_L2_PORTS(NP), .BANK_WORDS(BW)) u_checker (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .data_req_i (req[0]),
        .instr_req_i(req[1]),
        .data_gnt_i (gnt[0]),
        .instr_gnt_i(gnt[1]),
        .data_rsp_i (rsp[0]),
        .instr_rsp_i(rsp[1]),
        .test_id_i  (test_id),
        .data_err_o (data_err),
        .proto_err_o(proto_err),
        .pending_o  (pending)
    );

    bind soc_l2_top soc_l2_sva u_sva (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycles <= cycles + 1;

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("Run stopped, DUT did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // Master drivers
    //////////////////////////////////////////////////

    // Holds the request until granted, stays asserted for back to back use
    task automatic access(input int m, input logic rd, input addr_t a, input data_t d,
                          input be_t be);
        @(negedge clk_i);
        req[m] = '{req: 1'b1, wen: rd, add: a, wdata: d, be: be};
        @(posedge clk_i);
        while (!gnt[m]) @(posedge clk_i);
    endtask

    task automatic release_req(input int m);
        @(negedge clk_i);
        req[m].req = 1'b0;
    endtask

    // Random word in one of the two private banks
    function automatic addr_t priv_addr();
        addr_t base;
        base = $random(seed) & 1 ? PRIV1_START : PRIV0_START;
        return base + ((addr_t'($random(seed)) & (BW - 1)) << 2);
    endfunction

    initial begin
        seed    = 60865;
        cycles  = 0;
        test_id = 0;
        req[0]  = '0;
        req[1]  = '0;
        rst_n_i = 1'b0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Private banks, write from one master and read back from the other
        test_id = 1;
        for (int i = 0; i < N1; i++) begin
            a0[i] = priv_addr();
            a1[i] = priv_addr();
            fork
                begin
                    access(0, 1'b0, a0[i], $random(seed), be_t'($random(seed)));
                    release_req(0);
                end
                begin
                    access(1, 1'b0, a1[i], $random(seed), be_t'($random(seed)));
                    release_req(1);
                end
            join
        end
        for (int i = 0; i < N1; i++) begin
            fork
                begin
                    access(0, 1'b1, a1[i], '0, '0);
                    release_req(0);
                end
                begin
                    access(1, 1'b1, a0[i], '0, '0);
                    release_req(1);
                end
            join
        end

        // Legacy alias on the data port only
        test_id = 2;
        for (int i = 0; i < N2; i++) begin
            a0[i] = priv_addr();
            access(0, 1'b0, {ALIAS_FROM, a0[i][19:0]}, $random(seed), 4'hF);
            access(1, 1'b1, a0[i], '0, '0);
            access(1, 1'b1, {ALIAS_FROM, a0[i][19:0]}, '0, '0);
            release_req(1);
        end
        release_req(0);

        // Consecutive words across the interleaved banks
        test_id = 3;
        for (int i = 0; i < N3; i++) access(0, 1'b0, L2_INTLV_START + 4 * i, $random(seed), 4'hF);
        release_req(0);
        for (int i = 0; i < N3; i++) access(1, 1'b1, L2_INTLV_START + 4 * i, '0, '0);
        for (int i = N3; i < 2 * N3; i++) begin
            access(1, 1'b0, L2_INTLV_START + 4 * i, $random(seed), 4'hF);
        end
        release_req(1);
        for (int i = N3; i < 2 * N3; i++) access(0, 1'b1, L2_INTLV_START + 4 * i, '0, '0);
        release_req(0);

        // Both masters hammer bank 0
        test_id = 4;
        fork
            begin
                for (int i = 0; i < N4; i++) begin
                    access(0, 1'($random(seed)), L2_INTLV_START + ((4 * NP) * (i % N3)),
                           $random(seed), be_t'($random(seed)));
                end
                release_req(0);
            end
            begin
                for (int i = 0; i < N4; i++) begin
                    access(1, 1'b1, L2_INTLV_START + ((4 * NP) * (i % N3)), '0, '0);
                end
                release_req(1);
            end
        join

        // Different targets in parallel, then misses, then read back
        test_id = 5;
        for (int i = 0; i < N5; i++) begin
            a0[i] = PRIV0_START + 4 * ($random(seed) & (BW - 1));
            a1[i] = PRIV1_START + 4 * ($random(seed) & (BW - 1));
            fork
                begin
                    access(0, 1'b0, a0[i], $random(seed), 4'hF);
                    release_req(0);
                end
                begin
                    access(1, 1'b0, a1[i], $random(seed), 4'hF);
                    release_req(1);
                end
            join
            fork
                access(0, 1'($random(seed)), 32'h2000_0000 | a0[i], $random(seed), 4'hF);
                access(1, 1'($random(seed)), 32'h3000_0000 | a1[i], $random(seed), 4'hF);
            join
            fork
                begin
                    access(0, 1'b1, a1[i], '0, '0);
                    release_req(0);
                end
                begin
                    access(1, 1'b1, a0[i], '0, '0);
                    release_req(1);
                end
            join
        end

        repeat (4) @(posedge clk_i);
        sva_err = u_dut.u_sva.fail_cnt;
        $display("Closing count: %0d data, %0d protocol, %0d assertion errors, %0d missing",
                 data_err, proto_err, sva_err, pending);
        if (data_err == 0 && proto_err == 0 && sva_err == 0 && pending == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/soc_l2_pkg.sv
verilog/l2_addr_decoder.sv
verilog/l2_arbiter.sv
verilog/l2_bank.sv
verilog/l2_resp_mux.sv
verilog/soc_l2_top.sv
bench/soc_l2_checker.sv
bench/soc_l2_sva.sv
bench/soc_l2_tb.sv
